// File: Bender.yml
package:
  name: comp_unit

sources:
  - comp_unit_pkg.sv
  - header_capture.sv
  - payload_buffer.sv
  - response_framer.sv
  - frame_ctrl.sv
  - dcr_status.sv
  - comp_unit.sv
  - target: test
    files:
      - tb_comp_unit.sv

// File: build.f
comp_unit_pkg.sv
header_capture.sv
payload_buffer.sv
response_framer.sv
frame_ctrl.sv
dcr_status.sv
comp_unit.sv
tb_comp_unit.sv

// File: comp_unit.sv
`timescale 1ns/100ps
`default_nettype none

module comp_unit
   import comp_unit_pkg::*;
#(
   parameter int FIFO_DEPTH = 16
) (
   input  wire logic         clk,
   input  wire logic         rst_n,
   input  wire llink_t       tx_link_i,
   input  wire logic         rx_dst_rdy_n_i,
   input  wire dcr_req_t     dcr_i,
   input  wire logic         rst_engine_ack_i,
   output logic              tx_dst_rdy_n_o,
   output llink_t            rx_link_o,
   output logic              dcr_ack_o,
   output logic [DATA_W-1:0] dcr_rdata_o,
   output logic              rst_engine_req_o
);

   hdr_info_t   info;
   ctrl_state_e state;
   llink_t      head;
   logic        hdr_en;
   logic        hdr_last;
   logic        pay_en;
   logic        drop_en;
   logic        credit_ok;
   logic        empty;
   logic        pop;
   logic        start_resp;
   logic        accept;
   logic        resp_done;
   logic        frame_done;

   frame_ctrl u_frame_ctrl (
      .clk              (clk),
      .rst_n            (rst_n),
      .rst_engine_ack_i (rst_engine_ack_i),
      .tx_link_i        (tx_link_i),
      .hdr_last         (hdr_last),
      .info             (info),
      .credit_ok        (credit_ok),
      .resp_done        (resp_done),
      .tx_dst_rdy_n_o   (tx_dst_rdy_n_o),
      .hdr_en           (hdr_en),
      .pay_en           (pay_en),
      .drop_en          (drop_en),
      .start_resp       (start_resp),
      .accept           (accept),
      .state_o          (state),
      .frame_done       (frame_done)
   );

   header_capture u_header_capture (
      .clk       (clk),
      .rst_n     (rst_n),
      .hdr_en    (hdr_en),
      .tx_link_i (tx_link_i),
      .hdr_last  (hdr_last),
      .info      (info)
   );

   payload_buffer #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_payload_buffer (
      .clk       (clk),
      .rst_n     (rst_n),
      .pay_en    (pay_en),
      .drop_en   (drop_en),
      .tx_link_i (tx_link_i),
      .pop       (pop),
      .head      (head),
      .empty     (empty),
      .credit_ok (credit_ok)
   );

   response_framer u_response_framer (
      .clk            (clk),
      .rst_n          (rst_n),
      .start_resp     (start_resp),
      .accept         (accept),
      .info           (info),
      .head           (head),
      .empty          (empty),
      .rx_dst_rdy_n_i (rx_dst_rdy_n_i),
      .rx_link_o      (rx_link_o),
      .pop            (pop),
      .resp_done      (resp_done)
   );

   dcr_status u_dcr_status (
      .clk              (clk),
      .rst_n            (rst_n),
      .dcr_i            (dcr_i),
      .state_o          (state),
      .info             (info),
      .frame_done       (frame_done),
      .dcr_ack_o        (dcr_ack_o),
      .dcr_rdata_o      (dcr_rdata_o),
      .rst_engine_req_o (rst_engine_req_o)
   );

endmodule

`default_nettype wire

// File: comp_unit_pkg.sv
`default_nettype none

package comp_unit_pkg;

   localparam int DATA_W    = 32;
   localparam int HDR_WORDS = 8;
   localparam int DCR_AW    = 10;

   // flag field of header word 4
   typedef enum logic [2:0] {
      OP_NONE   = 3'b000,
      OP_COPY   = 3'b001,
      OP_DECOMP = 3'b010,
      OP_COMP   = 3'b100
   } op_e;

   typedef enum logic [2:0] {
      CS_IDLE,
      CS_HEADER,
      CS_PAYLOAD,
      CS_DRAIN,
      CS_DONE
   } ctrl_state_e;

   // one locallink beat, flags active low
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [3:0]        rem;
      logic              sof_n;
      logic              eof_n;
      logic              sop_n;
      logic              eop_n;
      logic              src_rdy_n;
   } llink_t;

   typedef struct packed {
      logic [2:0]        flag;
      logic [DATA_W-1:0] len;
      logic [9:0]        task_idx;
   } hdr_info_t;

   typedef struct packed {
      logic [DCR_AW-1:0] abus;
      logic [DATA_W-1:0] dbus;
      logic              read;
      logic              write;
   } dcr_req_t;

   localparam llink_t LLINK_IDLE = '{
      data: '0, rem: '0, sof_n: 1'b1, eof_n: 1'b1,
      sop_n: 1'b1, eop_n: 1'b1, src_rdy_n: 1'b1
   };

   // dcr register map
   localparam logic [DCR_AW-1:0] DCR_ADDR_CTRL = 10'h000;
   localparam logic [DCR_AW-1:0] DCR_ADDR_HDR  = 10'h003;
   localparam logic [DCR_AW-1:0] DCR_ADDR_CNT  = 10'h005;

   function automatic op_e decode_op(input logic [2:0] flag);
      case (flag)
         3'b001:  return OP_COPY;
         3'b010:  return OP_DECOMP;
         3'b100:  return OP_COMP;
         default: return OP_NONE;
      endcase
   endfunction

endpackage

`default_nettype wire

// File: dcr_status.sv
`timescale 1ns/100ps
`default_nettype none

module dcr_status
   import comp_unit_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst_n,
   input  wire dcr_req_t    dcr_i,
   input  wire ctrl_state_e state_o,
   input  wire hdr_info_t   info,
   input  wire logic        frame_done,
   output logic             dcr_ack_o,
   output logic [DATA_W-1:0] dcr_rdata_o,
   output logic             rst_engine_req_o
);

   logic [DATA_W-1:0] rdata_mux;
   logic [15:0]       frame_cnt;
   logic              rst_hit;

   // bit 0 here is bit 31 in the dcr bus numbering
   assign rst_hit = dcr_i.write && (dcr_i.abus == DCR_ADDR_CTRL) && dcr_i.dbus[0];

   always_comb begin
      rdata_mux = '0;
      case (dcr_i.abus)
         DCR_ADDR_CTRL: rdata_mux[31:29] = state_o;
         DCR_ADDR_HDR: begin
            rdata_mux[31:29] = info.flag;
            rdata_mux[9:0]   = info.task_idx;
         end
         DCR_ADDR_CNT:  rdata_mux[15:0] = frame_cnt;
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      dcr_rdata_o <= rdata_mux;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dcr_ack_o        <= 1'b0;
         rst_engine_req_o <= 1'b0;
         frame_cnt        <= '0;
      end else begin
         dcr_ack_o        <= dcr_i.read || dcr_i.write;
         rst_engine_req_o <= rst_hit && !rst_engine_req_o;
         if (frame_done) begin
            frame_cnt <= frame_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: frame_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module frame_ctrl
   import comp_unit_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      rst_n,
   input  wire logic      rst_engine_ack_i,
   input  wire llink_t    tx_link_i,
   input  wire logic      hdr_last,
   input  wire hdr_info_t info,
   input  wire logic      credit_ok,
   input  wire logic      resp_done,
   output logic           tx_dst_rdy_n_o,
   output logic           hdr_en,
   output logic           pay_en,
   output logic           drop_en,
   output logic           start_resp,
   output logic           accept,
   output ctrl_state_e    state_o,
   output logic           frame_done
);

   ctrl_state_e state;
   ctrl_state_e state_nxt;
   op_e         op;
   logic        eng_rst_n;
   logic        beat;
   logic        resp_seen;

   // engine reset also taken from the dma acknowledge
   assign eng_rst_n = rst_n && !rst_engine_ack_i;

   assign op     = decode_op(info.flag);
   assign accept = (op == OP_COPY);
   assign beat   = !tx_link_i.src_rdy_n && !tx_dst_rdy_n_o;

   assign hdr_en     = (state == CS_HEADER) || (state == CS_IDLE && !tx_link_i.sof_n);
   assign pay_en     = (state == CS_PAYLOAD);
   assign drop_en    = (state == CS_DRAIN);
   assign start_resp = hdr_last;
   assign state_o    = state;

   // a header-only response may finish while payload is still being dropped
   assign frame_done = (state == CS_DONE) && (resp_done || resp_seen);

   always_comb begin
      case (state)
         CS_IDLE,
         CS_HEADER,
         CS_DRAIN:   tx_dst_rdy_n_o = 1'b0;
         CS_PAYLOAD: tx_dst_rdy_n_o = !credit_ok;
         default:    tx_dst_rdy_n_o = 1'b1;
      endcase
   end

   always_comb begin
      state_nxt = state;
      case (state)
         CS_IDLE: begin
            if (beat && !tx_link_i.sof_n) begin
               state_nxt = CS_HEADER;
            end
         end
         CS_HEADER: begin
            if (hdr_last) begin
               state_nxt = accept ? CS_PAYLOAD : CS_DRAIN;
            end
         end
         CS_PAYLOAD,
         CS_DRAIN: begin
            if (beat && !tx_link_i.eop_n) begin
               state_nxt = CS_DONE;
            end
         end
         CS_DONE: begin
            if (frame_done) begin
               state_nxt = CS_IDLE;
            end
         end
         default: state_nxt = CS_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!eng_rst_n) begin
         state     <= CS_IDLE;
         resp_seen <= 1'b0;
      end else begin
         state <= state_nxt;
         if (frame_done) begin
            resp_seen <= 1'b0;
         end else if (resp_done) begin
            resp_seen <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: header_capture.sv
`timescale 1ns/100ps
`default_nettype none

module header_capture
   import comp_unit_pkg::*;
(
   input  wire logic   clk,
   input  wire logic   rst_n,
   input  wire logic   hdr_en,
   input  wire llink_t tx_link_i,
   output logic        hdr_last,
   output hdr_info_t   info
);

   localparam int CW = $clog2(HDR_WORDS);

   logic [CW-1:0] cnt;
   logic [CW-1:0] word_idx;
   logic          beat;

   assign beat     = hdr_en && !tx_link_i.src_rdy_n;
   // sof restarts the count
   assign word_idx = tx_link_i.sof_n ? cnt : '0;
   assign hdr_last = beat && (word_idx == CW'(HDR_WORDS - 1));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt  <= '0;
         info <= '0;
      end else if (beat) begin
         cnt <= word_idx + 1'b1;
         case (word_idx)
            CW'(4):  info.flag     <= tx_link_i.data[31:29];
            CW'(5):  info.len      <= tx_link_i.data;
            CW'(6):  info.task_idx <= tx_link_i.data[9:0];
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: payload_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module payload_buffer
   import comp_unit_pkg::*;
#(
   parameter int FIFO_DEPTH = 16
) (
   input  wire logic   clk,
   input  wire logic   rst_n,
   input  wire logic   pay_en,
   input  wire logic   drop_en,
   input  wire llink_t tx_link_i,
   input  wire logic   pop,
   output llink_t      head,
   output logic        empty,
   output logic        credit_ok
);

   localparam int AW = $clog2(FIFO_DEPTH);

   llink_t      mem [FIFO_DEPTH];
   logic [AW:0] wr_ptr;
   logic [AW:0] rd_ptr;
   logic [AW:0] credits;
   logic        push;

   assign credit_ok = (credits != '0);

   // dropped beats never reach the fifo and cost no credit
   assign push = pay_en && !drop_en && credit_ok && !tx_link_i.src_rdy_n;

   // extra pointer bit tells full from empty
   assign empty = (wr_ptr == rd_ptr);
   assign head  = mem[rd_ptr[AW-1:0]];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr[AW-1:0]] <= tx_link_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // one credit per free slot
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         credits <= (AW + 1)'(FIFO_DEPTH);
      end else begin
         case ({push, pop})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: response_framer.sv
`timescale 1ns/100ps
`default_nettype none

module response_framer
   import comp_unit_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      rst_n,
   input  wire logic      start_resp,
   input  wire logic      accept,
   input  wire hdr_info_t info,
   input  wire llink_t    head,
   input  wire logic      empty,
   input  wire logic      rx_dst_rdy_n_i,
   output llink_t         rx_link_o,
   output logic           pop,
   output logic           resp_done
);

   localparam int CW = $clog2(HDR_WORDS);

   llink_t        out_q;
   llink_t        hdr_beat;
   llink_t        pay_beat;
   logic [CW-1:0] hdr_cnt;
   logic [CW-1:0] idx;
   logic          hdr_phase;
   logic          pay_phase;
   logic          load_ok;

   assign rx_link_o = out_q;

   // output slot is free or being taken this cycle
   assign load_ok   = out_q.src_rdy_n || !rx_dst_rdy_n_i;
   assign idx       = start_resp ? '0 : hdr_cnt;
   assign pop       = load_ok && !start_resp && !hdr_phase && pay_phase && !empty;
   assign resp_done = !out_q.src_rdy_n && !rx_dst_rdy_n_i && !out_q.eof_n;

   always_comb begin
      hdr_beat           = LLINK_IDLE;
      hdr_beat.src_rdy_n = 1'b0;
      hdr_beat.sof_n     = (idx != '0);
      // header-only response ends on word 7
      hdr_beat.eof_n     = accept || (idx != CW'(HDR_WORDS - 1));
      case (idx)
         CW'(4):  hdr_beat.data = {info.flag, accept, 28'h0};
         CW'(5):  hdr_beat.data = info.len;
         CW'(6):  hdr_beat.data = {22'h0, info.task_idx};
         default: hdr_beat.data = '0;
      endcase
   end

   always_comb begin
      pay_beat           = head;
      pay_beat.src_rdy_n = 1'b0;
      pay_beat.sof_n     = 1'b1;
      pay_beat.eof_n     = head.eop_n;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_q     <= LLINK_IDLE;
         hdr_cnt   <= '0;
         hdr_phase <= 1'b0;
         pay_phase <= 1'b0;
      end else if (start_resp) begin
         out_q     <= hdr_beat;
         hdr_cnt   <= CW'(1);
         hdr_phase <= 1'b1;
      end else if (load_ok) begin
         if (hdr_phase) begin
            out_q   <= hdr_beat;
            hdr_cnt <= hdr_cnt + 1'b1;
            if (hdr_cnt == CW'(HDR_WORDS - 1)) begin
               hdr_phase <= 1'b0;
               pay_phase <= accept;
            end
         end else if (pop) begin
            out_q     <= pay_beat;
            pay_phase <= head.eop_n;
         end else begin
            out_q <= LLINK_IDLE;
         end
      end
   end

endmodule

`default_nettype wire

// File: tb_comp_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_comp_unit
   import comp_unit_pkg::*;
();

   localparam int FIFO_DEPTH = 16;
   localparam int TIMEOUT    = 1000;

   logic              clk;
   logic              rst_n;
   llink_t            tx_link;
   logic              tx_dst_rdy_n;
   llink_t            rx_link;
   logic              rx_dst_rdy_n;
   dcr_req_t          dcr;
   logic              dcr_ack;
   logic [DATA_W-1:0] dcr_rdata;
   logic              rst_engine_req;
   logic              rst_engine_ack;

   int                seed;
   int                frames;
   logic [2:0]        last_flag;
   logic [9:0]        last_task;
   llink_t            tx_q [$];
   llink_t            exp_q [$];
   llink_t            rx_q [$];

   comp_unit #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) DUT (
      .clk              (clk),
      .rst_n            (rst_n),
      .tx_link_i        (tx_link),
      .rx_dst_rdy_n_i   (rx_dst_rdy_n),
      .dcr_i            (dcr),
      .rst_engine_ack_i (rst_engine_ack),
      .tx_dst_rdy_n_o   (tx_dst_rdy_n),
      .rx_link_o        (rx_link),
      .dcr_ack_o        (dcr_ack),
      .dcr_rdata_o      (dcr_rdata),
      .rst_engine_req_o (rst_engine_req)
   );

   always #2 clk = ~clk;

   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check_beat(input string name, input llink_t exp, input llink_t act);
      string msg;
      if (exp.data !== act.data || exp.rem !== act.rem || exp.sof_n !== act.sof_n ||
          exp.eof_n !== act.eof_n || exp.sop_n !== act.sop_n ||
          exp.eop_n !== act.eop_n || exp.src_rdy_n !== act.src_rdy_n) begin
         msg = $sformatf("FAIL %s expected data=%h rem=%h sof_n=%b eof_n=%b",
                         name, exp.data, exp.rem, exp.sof_n, exp.eof_n);
         msg = {msg, $sformatf(" sop_n=%b eop_n=%b", exp.sop_n, exp.eop_n)};
         msg = {msg, $sformatf(" actual data=%h rem=%h sof_n=%b eof_n=%b",
                               act.data, act.rem, act.sof_n, act.eof_n)};
         msg = {msg, $sformatf(" sop_n=%b eop_n=%b", act.sop_n, act.eop_n)};
         fail_stop(msg);
      end
   endtask

   task automatic check_dcr(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
      if (exp !== act) begin
         fail_stop($sformatf("FAIL %s expected %h actual %h", name, exp, act));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         fail_stop($sformatf("FAIL %s expected %b actual %b", name, exp, act));
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (exp != act) begin
         fail_stop($sformatf("FAIL %s expected %0d actual %0d", name, exp, act));
      end
   endtask

   // response header word as the engine should send it
   function automatic llink_t resp_header(input int idx, input logic [2:0] flag,
                                          input logic [31:0] len, input logic [9:0] task_idx,
                                          input bit acc);
      llink_t b;
      b           = LLINK_IDLE;
      b.src_rdy_n = 1'b0;
      b.sof_n     = (idx != 0);
      b.eof_n     = acc || (idx != HDR_WORDS - 1);
      case (idx)
         4:       b.data = {flag, acc, 28'h0};
         5:       b.data = len;
         6:       b.data = {22'h0, task_idx};
         default: b.data = '0;
      endcase
      return b;
   endfunction

   task automatic build_frame(input logic [2:0] flag, input int n_pay,
                              input logic [3:0] last_rem, input logic [9:0] task_idx);
      llink_t      b;
      logic [31:0] len;
      bit          acc;
      tx_q.delete();
      exp_q.delete();
      len = 32'(n_pay * 4);
      // only the copy flag is accepted
      acc = (flag == 3'b001);
      for (int i = 0; i < HDR_WORDS; i++) begin
         b           = LLINK_IDLE;
         b.src_rdy_n = 1'b0;
         b.sof_n     = (i != 0);
         b.data      = $random(seed);
         case (i)
            4:       b.data[31:29] = flag;
            5:       b.data = len;
            6:       b.data[9:0] = task_idx;
            default: ;
         endcase
         tx_q.push_back(b);
         exp_q.push_back(resp_header(i, flag, len, task_idx, acc));
      end
      for (int j = 0; j < n_pay; j++) begin
         b           = LLINK_IDLE;
         b.src_rdy_n = 1'b0;
         b.data      = $random(seed);
         b.rem       = (j == n_pay - 1) ? last_rem : 4'hf;
         b.sop_n     = (j != 0);
         b.eop_n     = (j != n_pay - 1);
         b.eof_n     = b.eop_n;
         tx_q.push_back(b);
         if (acc) begin
            exp_q.push_back(b);
         end
      end
   endtask

   // tx beats move on the falling edge, transfer at the next rising edge
   task automatic send_frame(input bit gaps);
      int i;
      int cyc;
      int wait_cnt;
      bit transfer;
      i        = 0;
      cyc      = 0;
      wait_cnt = 0;
      while (i < tx_q.size()) begin
         @(negedge clk);
         cyc++;
         transfer = 1'b0;
         if (gaps && (cyc % 5 == 4)) begin
            tx_link = LLINK_IDLE;
         end else begin
            tx_link  = tx_q[i];
            transfer = !tx_dst_rdy_n;
         end
         if (transfer) begin
            i++;
            wait_cnt = 0;
         end else begin
            wait_cnt++;
            if (wait_cnt > TIMEOUT) begin
               fail_stop("timeout: tx_dst_rdy_n_o stayed high while sending a frame");
            end
         end
      end
      @(negedge clk);
      tx_link = LLINK_IDLE;
   endtask

   task automatic collect_resp(input bit stall);
      int   idle;
      bit   done;
      logic rdy_n;
      idle = 0;
      done = 1'b0;
      rx_q.delete();
      while (!done) begin
         @(negedge clk);
         rdy_n        = stall && (($random(seed) & 1) != 0);
         rx_dst_rdy_n = rdy_n;
         if (!rx_link.src_rdy_n && !rdy_n) begin
            rx_q.push_back(rx_link);
            done = !rx_link.eof_n;
            idle = 0;
         end else begin
            idle++;
            if (idle > TIMEOUT) begin
               fail_stop("timeout: no receive beat with eof arrived");
            end
         end
      end
   endtask

   task automatic wait_idle();
      int cnt;
      cnt = 0;
      @(negedge clk);
      while (tx_dst_rdy_n) begin
         @(negedge clk);
         cnt++;
         if (cnt > TIMEOUT) begin
            fail_stop("timeout: engine did not return to idle after a frame");
         end
      end
   endtask

   task automatic run_frame(input string name, input logic [2:0] flag, input int n_pay,
                            input logic [3:0] last_rem, input logic [9:0] task_idx,
                            input bit stress);
      build_frame(flag, n_pay, last_rem, task_idx);
      fork
         send_frame(stress);
         collect_resp(stress);
      join
      check_count({name, " beat count"}, exp_q.size(), rx_q.size());
      for (int k = 0; k < exp_q.size(); k++) begin
         check_beat($sformatf("%s beat %0d", name, k), exp_q[k], rx_q[k]);
      end
      wait_idle();
      frames++;
      last_flag = flag;
      last_task = task_idx;
   endtask

   // ack must rise exactly one cycle after the request
   task automatic dcr_read(input logic [DCR_AW-1:0] addr, output logic [DATA_W-1:0] data);
      @(negedge clk);
      check_bit("dcr ack before read", 1'b0, dcr_ack);
      dcr.abus = addr;
      dcr.read = 1'b1;
      @(negedge clk);
      dcr.read = 1'b0;
      check_bit("dcr ack after read", 1'b1, dcr_ack);
      data = dcr_rdata;
      @(negedge clk);
      check_bit("dcr ack drop", 1'b0, dcr_ack);
   endtask

   task automatic check_reset_values();
      check_bit("reset rx src_rdy_n", 1'b1, rx_link.src_rdy_n);
      check_bit("reset rx sof_n", 1'b1, rx_link.sof_n);
      check_bit("reset rx eof_n", 1'b1, rx_link.eof_n);
      check_bit("reset engine req", 1'b0, rst_engine_req);
      check_bit("reset dcr ack", 1'b0, dcr_ack);
      check_bit("reset tx_dst_rdy_n", 1'b0, tx_dst_rdy_n);
   endtask

   task automatic test_copy_frame();
      run_frame("copy_frame", 3'b001, 5, 4'b0011, 10'h2a5, 1'b0);
   endtask

   task automatic test_compress_op();
      run_frame("compress_op", 3'b100, 4, 4'hf, 10'h13c, 1'b0);
      run_frame("copy_after_compress", 3'b001, 3, 4'b0001, 10'h077, 1'b0);
   endtask

   task automatic test_back_pressure();
      run_frame("back_pressure", 3'b001, 40, 4'b0111, 10'h3e1, 1'b1);
   endtask

   task automatic test_dcr_status();
      logic [DATA_W-1:0] rd;
      logic [2:0]        idle_state;
      idle_state = CS_IDLE;
      dcr_read(10'd3, rd);
      check_dcr("dcr_status header", {last_flag, 19'h0, last_task}, rd);
      dcr_read(10'd5, rd);
      check_dcr("dcr_status frame count", {16'h0, 16'(frames)}, rd);
      dcr_read(10'd0, rd);
      check_dcr("dcr_status state", {idle_state, 29'h0}, rd);
      dcr_read(10'd7, rd);
      check_dcr("dcr_status unmapped", 32'h0, rd);
   endtask

   task automatic test_engine_reset();
      logic [DATA_W-1:0] rd;
      logic [2:0]        hdr_state;
      hdr_state = CS_HEADER;
      // leave the engine stuck inside a header
      build_frame(3'b001, 2, 4'hf, 10'h0ab);
      while (tx_q.size() > 4) begin
         tx_q.pop_back();
      end
      send_frame(1'b0);
      dcr_read(10'd0, rd);
      check_dcr("engine_reset state before", {hdr_state, 29'h0}, rd);
      @(negedge clk);
      check_bit("engine_reset req before write", 1'b0, rst_engine_req);
      dcr.abus  = 10'd0;
      dcr.dbus  = 32'h1;
      dcr.write = 1'b1;
      @(negedge clk);
      dcr.write = 1'b0;
      dcr.dbus  = '0;
      check_bit("engine_reset dcr ack", 1'b1, dcr_ack);
      check_bit("engine_reset req pulse", 1'b1, rst_engine_req);
      rst_engine_ack = 1'b1;
      @(negedge clk);
      check_bit("engine_reset req one cycle", 1'b0, rst_engine_req);
      @(negedge clk);
      rst_engine_ack = 1'b0;
      dcr_read(10'd0, rd);
      check_dcr("engine_reset state after", 32'h0, rd);
      run_frame("copy_after_reset", 3'b001, 6, 4'b1111, 10'h155, 1'b0);
      dcr_read(10'd5, rd);
      check_dcr("engine_reset frame count", {16'h0, 16'(frames)}, rd);
   endtask

   initial begin
      clk            = 1'b0;
      rst_n          = 1'b0;
      tx_link        = LLINK_IDLE;
      rx_dst_rdy_n   = 1'b1;
      dcr            = '0;
      rst_engine_ack = 1'b0;
      seed           = 32'h5a6185da;
      frames         = 0;
      last_flag      = '0;
      last_task      = '0;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      check_reset_values();
      test_copy_frame();
      test_compress_op();
      test_back_pressure();
      test_dcr_status();
      test_engine_reset();
      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire
